// ==== rtl/div_cfg.svh ====
// Division unit configuration
// widths shared by the packages and the RTL blocks

`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// ======================================================================
// data widths
// ======================================================================
`define DIV_XLEN   64  // operand and result width
`define DIV_WLEN   32  // word operations (divw, remw ...)

// ======================================================================
// control widths
// ======================================================================
`define DIV_OP_W    8  // one-hot operation code
`define DIV_CNT_W   7  // holds 0..64 remaining quotient bits

`endif

// ==== rtl/div_isa_pkg.sv ====
// Division unit ISA package
// M-extension divide and remainder encodings and the request bundle

`include "div_cfg.svh"

package div_isa_pkg;

  // ======================================================================
  // basic value types
  // ======================================================================
  typedef logic [`DIV_XLEN-1:0] xlen_t;  // register sized value

  // one-hot operation code, bit order fixed by the decoder
  typedef enum logic [`DIV_OP_W-1:0] {
    OP_DIV   = 8'b1000_0000,  // signed 64
    OP_DIVU  = 8'b0100_0000,  // unsigned 64
    OP_DIVUW = 8'b0010_0000,  // unsigned 32
    OP_DIVW  = 8'b0001_0000,  // signed 32
    OP_REM   = 8'b0000_1000,  // signed 64
    OP_REMU  = 8'b0000_0100,  // unsigned 64
    OP_REMUW = 8'b0000_0010,  // unsigned 32
    OP_REMW  = 8'b0000_0001   // signed 32
  } div_op_e;

  // ======================================================================
  // request presented with start_i
  // ======================================================================
  typedef struct packed {
    div_op_e op;        // operation code
    xlen_t   dividend;  // rs1
    xlen_t   divisor;   // rs2
  } div_req_t;

endpackage

// ==== rtl/div_dp_pkg.sv ====
// Division unit datapath package
// controller states, accumulator layout and the load bundle

`include "div_cfg.svh"

package div_dp_pkg;

  // remainder in the upper half, quotient/dividend in the lower half
  typedef logic [2*`DIV_XLEN-1:0] acc_t;
  typedef logic [`DIV_CNT_W-1:0]  iter_cnt_t;  // remaining quotient bits

  typedef enum logic [1:0] {
    IDLE    = 2'b00,  // waiting for start
    ITERATE = 2'b01,  // one quotient bit per cycle
    FINISH  = 2'b10   // result held until ready
  } div_state_e;

  // ======================================================================
  // prepared operation, captured on accept
  // ======================================================================
  typedef struct packed {
    acc_t                 acc_init;     // start value or exception result
    div_isa_pkg::xlen_t   divisor_mag;  // divisor magnitude
    logic                 q_neg;        // negate quotient at the end
    logic                 r_neg;        // negate remainder at the end
    logic                 is_word;      // 32-bit operation
    logic                 is_exc;       // skip iteration
    div_isa_pkg::div_op_e op;           // operation code
  } div_load_t;

endpackage

// ==== rtl/div_operand_prep.sv ====
// Division operand preparation
// turns a request into magnitudes, result signs and exception values,
// purely combinational

`include "div_cfg.svh"

module div_operand_prep (
  input  div_isa_pkg::div_req_t req_i,
  output div_dp_pkg::div_load_t load_o
);
  import div_isa_pkg::*;

  logic                 op_legal;
  logic                 is_word;
  logic                 is_signed;
  logic                 is_rem;
  logic [`DIV_WLEN-1:0] dvd_w;      // low word of rs1
  logic [`DIV_WLEN-1:0] dvs_w;      // low word of rs2
  logic [`DIV_WLEN-1:0] dvd_abs_w;
  logic [`DIV_WLEN-1:0] dvs_abs_w;
  xlen_t                dvd_abs;
  xlen_t                dvs_abs;
  xlen_t                dvd_sext;   // rs1 word sign-extended
  logic                 dvd_neg;
  logic                 dvs_neg;
  logic                 div_zero;
  logic                 div_ovf;
  logic                 is_exc;
  xlen_t                exc_val;

  // ======================================================================
  // operation decode
  // ======================================================================
  assign op_legal  = req_i.op inside {OP_DIV, OP_DIVU, OP_DIVUW, OP_DIVW,
                                      OP_REM, OP_REMU, OP_REMUW, OP_REMW};
  assign is_word   = req_i.op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  assign is_signed = req_i.op inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};
  assign is_rem    = req_i.op inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};

  // ======================================================================
  // signs and magnitudes
  // ======================================================================
  assign dvd_w    = req_i.dividend[`DIV_WLEN-1:0];
  assign dvs_w    = req_i.divisor[`DIV_WLEN-1:0];
  assign dvd_sext = {{(`DIV_XLEN-`DIV_WLEN){dvd_w[`DIV_WLEN-1]}}, dvd_w};

  assign dvd_neg = is_signed & (is_word ? dvd_w[`DIV_WLEN-1] : req_i.dividend[`DIV_XLEN-1]);
  assign dvs_neg = is_signed & (is_word ? dvs_w[`DIV_WLEN-1] : req_i.divisor[`DIV_XLEN-1]);

  assign dvd_abs   = dvd_neg ? (~req_i.dividend + 1'b1) : req_i.dividend;
  assign dvs_abs   = dvs_neg ? (~req_i.divisor + 1'b1) : req_i.divisor;
  assign dvd_abs_w = dvd_neg ? (~dvd_w + 1'b1) : dvd_w;
  assign dvs_abs_w = dvs_neg ? (~dvs_w + 1'b1) : dvs_w;

  // ======================================================================
  // exceptions
  // ======================================================================
  assign div_zero = is_word ? (dvs_w == '0) : (req_i.divisor == '0);
  assign div_ovf  = is_signed & (is_word ?
                    (dvd_w == {1'b1, {(`DIV_WLEN-1){1'b0}}}) && (&dvs_w) :
                    (req_i.dividend == {1'b1, {(`DIV_XLEN-1){1'b0}}}) && (&req_i.divisor));
  assign is_exc   = ~op_legal | div_zero | div_ovf;

  always_comb begin
    exc_val = '0;  // illegal code gives zero
    if (op_legal && div_zero) begin
      exc_val = is_rem ? (is_word ? dvd_sext : req_i.dividend) : '1;
    end else if (op_legal && div_ovf) begin
      exc_val = is_rem ? '0 : (is_word ? dvd_sext : req_i.dividend);
    end
  end

  // ======================================================================
  // load bundle
  // ======================================================================
  always_comb begin
    if (is_exc) begin
      load_o.acc_init = {{`DIV_XLEN{1'b0}}, exc_val};  // final value in low half
    end else if (is_word) begin
      // word magnitude on top of the low half, 32 steps shift it out
      load_o.acc_init = {{`DIV_XLEN{1'b0}}, dvd_abs_w, {`DIV_WLEN{1'b0}}};
    end else begin
      load_o.acc_init = {{`DIV_XLEN{1'b0}}, dvd_abs};
    end
    load_o.divisor_mag = is_word ? {{(`DIV_XLEN-`DIV_WLEN){1'b0}}, dvs_abs_w} : dvs_abs;
    load_o.q_neg       = dvd_neg ^ dvs_neg;
    load_o.r_neg       = dvd_neg;  // remainder follows the dividend
    load_o.is_word     = is_word;
    load_o.is_exc      = is_exc;
    load_o.op          = req_i.op;
  end

endmodule

// ==== rtl/div_iter_counter.sv ====
// Division iteration counter
// counts the quotient bits still to be produced

`include "div_cfg.svh"

module div_iter_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic load_i,     // operation accepted
  input  logic is_word_i,  // 32 instead of 64 bits
  input  logic step_i,     // one quotient bit done
  output logic zero_o
);
  import div_dp_pkg::*;

  iter_cnt_t cnt_q;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= is_word_i ? iter_cnt_t'(`DIV_WLEN) : iter_cnt_t'(`DIV_XLEN);
    end else if (step_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign zero_o = (cnt_q == '0);

  // controller must stop stepping once the count runs out
  a_no_step_at_zero: assert property (
    @(posedge clk) disable iff (rst_n)
    step_i |-> !zero_o
  ) else $error("div_iter_counter: step with zero count");

endmodule

// ==== rtl/div_ctrl.sv ====
// Division controller
// sequences accept, iteration and result hand-off

module div_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,     // sampled in IDLE only
  input  logic is_exc_i,    // exception, no iteration
  input  logic cnt_zero_i,  // all quotient bits done
  input  logic ready_i,     // consumer takes the result
  output logic load_o,
  output logic step_o,
  output logic busy_o,
  output logic done_o
);
  import div_dp_pkg::*;

  div_state_e state_q;
  div_state_e state_d;

  // ======================================================================
  // next state
  // ======================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = is_exc_i ? FINISH : ITERATE;
        end
      end
      ITERATE: begin
        if (cnt_zero_i) begin
          state_d = FINISH;
        end
      end
      FINISH: begin
        if (ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign load_o = (state_q == IDLE) & start_i;         // accept cycle
  assign step_o = (state_q == ITERATE) & ~cnt_zero_i;
  assign busy_o = load_o | (state_q == ITERATE);
  assign done_o = (state_q == FINISH);

  a_busy_done_excl: assert property (@(posedge clk) disable iff (rst_n) !(busy_o && done_o))
    else $error("div_ctrl: busy and done together");
  a_load_once: assert property (@(posedge clk) disable iff (rst_n) load_o |=> !load_o)
    else $error("div_ctrl: load in two consecutive cycles");

endmodule

// ==== rtl/div_shift_sub.sv ====
// Division shift-subtract datapath
// restoring algorithm on magnitudes, one quotient bit per step

`include "div_cfg.svh"

module div_shift_sub (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load_i,
  input  logic                  step_i,
  input  div_dp_pkg::div_load_t load_data_i,
  output div_dp_pkg::acc_t      acc_o
);
  import div_isa_pkg::*;
  import div_dp_pkg::*;

  acc_t               acc_q;      // {remainder, quotient/dividend}
  xlen_t              divisor_q;  // divisor magnitude
  logic [`DIV_XLEN:0] partial;    // shifted remainder with its carry bit
  logic [`DIV_XLEN:0] diff;

  // ======================================================================
  // trial subtraction
  // ======================================================================
  // upper half after a one bit left shift, keeping the bit that would
  // fall off the top so large divisors still compare correctly
  assign partial = acc_q[2*`DIV_XLEN-1:`DIV_XLEN-1];
  assign diff    = partial - {1'b0, divisor_q};  // msb set means negative

  always_ff @(posedge clk) begin
    if (rst_n) begin
      acc_q     <= '0;
      divisor_q <= '0;
    end else if (load_i) begin
      acc_q     <= load_data_i.acc_init;
      divisor_q <= load_data_i.divisor_mag;
    end else if (step_i) begin
      if (diff[`DIV_XLEN]) begin
        acc_q <= {acc_q[2*`DIV_XLEN-2:0], 1'b0};                      // restore, bit 0
      end else begin
        acc_q <= {diff[`DIV_XLEN-1:0], acc_q[`DIV_XLEN-2:0], 1'b1};  // keep diff, bit 1
      end
    end
  end

  assign acc_o = acc_q;

endmodule

// ==== rtl/div_result_fmt.sv ====
// Division result formatting
// picks quotient or remainder, restores its sign and extends word results

`include "div_cfg.svh"

module div_result_fmt (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  load_i,
  input  div_dp_pkg::div_load_t load_data_i,
  input  div_dp_pkg::acc_t      acc_i,
  input  logic                  finish_i,   // result valid
  output div_isa_pkg::xlen_t    result_o
);
  import div_isa_pkg::*;

  logic    q_neg_q;
  logic    r_neg_q;
  logic    is_word_q;
  logic    is_exc_q;
  div_op_e op_q;      // operation of the accepted request
  logic    is_rem;
  xlen_t   quo_s;
  xlen_t   rem_s;
  xlen_t   sel;
  xlen_t   res;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      q_neg_q   <= 1'b0;
      r_neg_q   <= 1'b0;
      is_word_q <= 1'b0;
      is_exc_q  <= 1'b0;
      op_q      <= OP_DIV;
    end else if (load_i) begin
      q_neg_q   <= load_data_i.q_neg;
      r_neg_q   <= load_data_i.r_neg;
      is_word_q <= load_data_i.is_word;
      is_exc_q  <= load_data_i.is_exc;
      op_q      <= load_data_i.op;
    end
  end

  assign is_rem = op_q inside {OP_REM, OP_REMU, OP_REMW, OP_REMUW};
  assign quo_s  = q_neg_q ? (~acc_i[`DIV_XLEN-1:0] + 1'b1) : acc_i[`DIV_XLEN-1:0];
  assign rem_s  = r_neg_q ? (~acc_i[2*`DIV_XLEN-1:`DIV_XLEN] + 1'b1)
                          : acc_i[2*`DIV_XLEN-1:`DIV_XLEN];
  assign sel    = is_rem ? rem_s : quo_s;

  // exception values arrive already formatted in the low half
  assign res = is_exc_q  ? acc_i[`DIV_XLEN-1:0] :
               is_word_q ? {{(`DIV_XLEN-`DIV_WLEN){sel[`DIV_WLEN-1]}}, sel[`DIV_WLEN-1:0]} :
                           sel;

  assign result_o = finish_i ? res : '0;

endmodule

// ==== rtl/div_unit_top.sv ====
// Integer division unit
// RV64 M-extension div/rem, restoring radix-2, one bit per cycle

module div_unit_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  div_isa_pkg::div_req_t req_i,
  input  logic                  ready_i,
  output div_isa_pkg::xlen_t    result_o,
  output logic                  busy_o,
  output logic                  done_o
);
  import div_dp_pkg::*;

  div_load_t load_data;  // prepared operation
  acc_t      acc;
  logic      load;
  logic      step;
  logic      cnt_zero;

  div_operand_prep u_prep (.req_i(req_i), .load_o(load_data));

  div_ctrl u_ctrl (
    .clk(clk), .rst_n(rst_n), .start_i(start_i), .is_exc_i(load_data.is_exc),
    .cnt_zero_i(cnt_zero), .ready_i(ready_i), .load_o(load), .step_o(step),
    .busy_o(busy_o), .done_o(done_o)
  );

  div_iter_counter u_cnt (
    .clk(clk), .rst_n(rst_n), .load_i(load), .is_word_i(load_data.is_word),
    .step_i(step), .zero_o(cnt_zero)
  );

  div_shift_sub u_dp (
    .clk(clk), .rst_n(rst_n), .load_i(load), .step_i(step),
    .load_data_i(load_data), .acc_o(acc)
  );

  div_result_fmt u_fmt (
    .clk(clk), .rst_n(rst_n), .load_i(load), .load_data_i(load_data),
    .acc_i(acc), .finish_i(done_o), .result_o(result_o)
  );

endmodule

// ==== tb/div_tb.sv ====
// Division unit testbench
// directed tests of the eight div/rem operations against a RISC-V model

module div_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import div_isa_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;  // longest legal wait is 65 edges

  localparam div_op_e ALL_OPS [8] = '{OP_DIV, OP_DIVU, OP_DIVUW, OP_DIVW,
                                      OP_REM, OP_REMU, OP_REMUW, OP_REMW};
  localparam xlen_t FIX_A [6] = '{64'd20, -64'd20, 64'd20, -64'd20,
                                  64'hffff_ffff_ffff_fff1, 64'hdead_beef_8000_0007};
  localparam xlen_t FIX_B [6] = '{64'd6, 64'd6, -64'd6, -64'd6,
                                  64'd3, 64'h0123_4567_ffff_fffd};

  logic     clk;
  logic     rst_n;
  logic     start_i;
  div_req_t req_i;
  logic     ready_i;
  xlen_t    result_o;
  logic     busy_o;
  logic     done_o;
  integer   seed;

  div_unit_top UUT (
    .clk(clk), .rst_n(rst_n), .start_i(start_i), .req_i(req_i), .ready_i(ready_i),
    .result_o(result_o), .busy_o(busy_o), .done_o(done_o)
  );

  always #4 clk = ~clk;  // 8 ns period

  // ======================================================================
  // error reporting
  // ======================================================================
  task automatic fail_stop();
    $display("=== FAIL ===");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_eq(input string name, input xlen_t got, input xlen_t exp);
    assert (got === exp) else begin
      $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
      fail_stop();
    end
  endtask

  // ======================================================================
  // RISC-V reference rules
  // ======================================================================
  function automatic bit is_legal_op(input div_op_e op);
    return op inside {OP_DIV, OP_DIVU, OP_DIVUW, OP_DIVW,
                      OP_REM, OP_REMU, OP_REMUW, OP_REMW};
  endfunction

  function automatic bit is_word_op(input div_op_e op);
    return op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  endfunction

  function automatic bit divides_by_zero(input div_op_e op, input xlen_t b);
    return is_word_op(op) ? (b[31:0] == '0) : (b == '0);
  endfunction

  function automatic bit overflows(input div_op_e op, input xlen_t a, input xlen_t b);
    if (op inside {OP_DIV, OP_REM}) begin
      return (a == 64'h8000_0000_0000_0000) && (b == '1);
    end
    if (op inside {OP_DIVW, OP_REMW}) begin
      return (a[31:0] == 32'h8000_0000) && (b[31:0] == '1);
    end
    return 1'b0;
  endfunction

  function automatic bit skips_iteration(input div_op_e op, input xlen_t a, input xlen_t b);
    return !is_legal_op(op) || divides_by_zero(op, b) || overflows(op, a, b);
  endfunction

  function automatic xlen_t riscv_div(input div_op_e op, input xlen_t a, input xlen_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic [31:0]        ua;
    logic [31:0]        ub;
    logic [31:0]        w;
    logic               dz;
    logic               ov;
    xlen_t              r;
    sa = a;
    sb = b;
    wa = a[31:0];
    wb = b[31:0];
    ua = a[31:0];
    ub = b[31:0];
    dz = divides_by_zero(op, b);
    ov = overflows(op, a, b);
    r  = '0;                         // illegal codes give zero
    w  = '0;
    case (op)
      OP_DIV:   r = dz ? '1 : (ov ? a : xlen_t'(sa / sb));
      OP_DIVU:  r = dz ? '1 : a / b;
      OP_REM:   r = dz ? a : (ov ? '0 : xlen_t'(sa % sb));
      OP_REMU:  r = dz ? a : a % b;
      OP_DIVW:  w = dz ? '1 : (ov ? ua : 32'(wa / wb));
      OP_DIVUW: w = dz ? '1 : ua / ub;
      OP_REMW:  w = dz ? ua : (ov ? '0 : 32'(wa % wb));
      OP_REMUW: w = dz ? ua : ua % ub;
      default:  r = '0;
    endcase
    if (is_word_op(op)) begin
      r = {{32{w[31]}}, w};          // word results extend bit 31
    end
    return r;
  endfunction

  function automatic xlen_t rand_operand();
    xlen_t v;
    v = {$random(seed), $random(seed)};
    v = v >> ($unsigned($random(seed)) % 64);  // spread the magnitudes
    if ($random(seed) & 1) begin
      v = -v;
    end
    return v;
  endfunction

  // ======================================================================
  // driver tasks
  // ======================================================================
  // drives one operation at edge + 1 ns and waits for done_o
  task automatic start_and_wait(input div_op_e op, input xlen_t a, input xlen_t b,
                                output xlen_t res);
    int    edges;
    int    expect_edges;
    xlen_t expect_res;
    expect_res   = riscv_div(op, a, b);
    expect_edges = skips_iteration(op, a, b) ? 0 : (is_word_op(op) ? 33 : 65);
    start_i        = 1'b1;
    req_i.op       = op;
    req_i.dividend = a;
    req_i.divisor  = b;
    #1;
    check_eq("busy_o", xlen_t'(busy_o), xlen_t'(1));  // accept cycle
    @(posedge clk);
    #1;
    start_i = 1'b0;
    req_i   = '0;                    // unit works from its captured copy
    edges   = 0;
    while (!done_o) begin
      check_eq("busy_o", xlen_t'(busy_o), xlen_t'(1));
      assert (edges < TIMEOUT_CYCLES) else begin
        $display("timeout at %0t: done_o never rose for %s", $time, op.name());
        fail_stop();
      end
      @(posedge clk);
      #1;
      edges++;
    end
    check_eq("done_o latency", xlen_t'(edges), xlen_t'(expect_edges));
    check_eq("busy_o", xlen_t'(busy_o), xlen_t'(0));
    check_eq("result_o", result_o, expect_res);
    res = result_o;
  endtask

  task automatic release_result();
    ready_i = 1'b1;
    @(posedge clk);
    #1;
    check_eq("done_o", xlen_t'(done_o), xlen_t'(0));
    check_eq("result_o", result_o, '0);  // zero outside FINISH
  endtask

  task automatic run_op(input div_op_e op, input xlen_t a, input xlen_t b);
    xlen_t res;
    start_and_wait(op, a, b, res);
    release_result();
  endtask

  // ======================================================================
  // tests
  // ======================================================================
  task automatic verify_reset_state();
    check_eq("busy_o", xlen_t'(busy_o), xlen_t'(0));
    check_eq("done_o", xlen_t'(done_o), xlen_t'(0));
    check_eq("result_o", result_o, '0);
  endtask

  task automatic sweep_operations();
    int k;
    int n;
    for (k = 0; k < 8; k++) begin
      for (n = 0; n < 6; n++) begin
        run_op(ALL_OPS[k], FIX_A[n], FIX_B[n]);
      end
      for (n = 0; n < 40; n++) begin
        run_op(ALL_OPS[k], rand_operand(), rand_operand());
      end
    end
  endtask

  task automatic cover_exceptions();
    int k;
    for (k = 0; k < 8; k++) begin
      run_op(ALL_OPS[k], rand_operand(), 64'd0);
      run_op(ALL_OPS[k], 64'hfedc_ba98_7654_3210, 64'hffff_ffff_0000_0000);  // word zero
    end
    run_op(OP_DIV, 64'h8000_0000_0000_0000, '1);
    run_op(OP_REM, 64'h8000_0000_0000_0000, '1);
    run_op(OP_DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    run_op(OP_REMW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    run_op(div_op_e'(8'h03), 64'd100, 64'd7);  // illegal codes
    run_op(div_op_e'(8'h00), 64'd100, 64'd7);
  endtask

  task automatic hold_under_backpressure();
    xlen_t held;
    int    i;
    ready_i = 1'b0;
    start_and_wait(OP_DIV, -64'd12345, 64'd77, held);
    for (i = 0; i < 10; i++) begin
      start_i = (i == 4);            // must be ignored in FINISH
      req_i.op       = OP_DIVU;
      req_i.dividend = 64'd99;
      req_i.divisor  = 64'd0;
      @(posedge clk);
      #1;
      check_eq("done_o", xlen_t'(done_o), xlen_t'(1));
      check_eq("busy_o", xlen_t'(busy_o), xlen_t'(0));
      check_eq("result_o", result_o, held);
    end
    start_i = 1'b0;
    release_result();
    run_op(OP_REMU, 64'hffff_0000_1234_5678, 64'd1000);
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b1;                  // in reset while high
    start_i = 1'b0;
    req_i   = '0;
    ready_i = 1'b1;
    seed    = 34690;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b0;
    verify_reset_state();
    run_op(OP_DIVU, 64'd1000, 64'd7);   // 65 edge latency
    run_op(OP_DIVUW, 64'd1000, 64'd7);  // 33 edge latency
    sweep_operations();
    cover_exceptions();
    hold_under_backpressure();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/div_isa_pkg.sv
rtl/div_dp_pkg.sv
rtl/div_operand_prep.sv
rtl/div_iter_counter.sv
rtl/div_ctrl.sv
rtl/div_shift_sub.sv
rtl/div_result_fmt.sv
rtl/div_unit_top.sv
tb/div_tb.sv

// ==== Makefile ====
# Verilator build and run for the division unit testbench

VERILATOR ?= verilator
TOP       ?= div_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= === PASS ===
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
